// ==== hw/boot_pkg.sv ====
// Shared widths, command and write formats, and MMIO register offsets for the boot stub.
// Modules and the testbench reference these by scoped names.

package boot_pkg;

  // ----------------------------------------
  // Basic widths
  // ----------------------------------------

  // MMIO register offset
  typedef logic [7:0] addr_t;

  // Register data word
  typedef logic [31:0] data_t;

  // ----------------------------------------
  // Command format
  // ----------------------------------------

  // Command opcodes as stored in the command memory
  typedef enum logic [1:0] {
    op_nop   = 2'd0,
    op_write = 2'd1,
    op_halt  = 2'd2
  } op_t;

  // One command word, 42 bits
  typedef struct packed {
    op_t   op;
    addr_t addr;
    data_t data;
  } cmd_t;

  // One queued register write, 40 bits
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_req_t;

  // ----------------------------------------
  // MMIO register map
  // ----------------------------------------

  localparam addr_t reg_sig_load = 8'h00;
  localparam addr_t reg_sig_xor  = 8'h04;
  localparam addr_t reg_poweroff = 8'h08;
  localparam addr_t reg_uart_tx  = 8'h0c;

  // Any other offset is silently dropped by the register block

endpackage : boot_pkg

// ==== hw/cmd_store.sv ====
// Command memory for the boot sequencer.
// The host fills it through the load port, the sequencer reads with one cycle of latency.

`timescale 1ns/1ns

module cmd_store #(
  parameter int unsigned CMD_AW = 5
) (
  input  logic                  clk,

  // Host load port
  input  logic                  load_we,
  input  logic [CMD_AW-1:0]     load_addr,
  input  boot_pkg::cmd_t        load_cmd,

  // Sequencer read port
  input  logic [CMD_AW-1:0]     rd_addr,
  output boot_pkg::cmd_t        rd_cmd
);

  localparam int unsigned DEPTH = 2 ** CMD_AW;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Command words as loaded by the host
  boot_pkg::cmd_t mem [DEPTH];

  // Synchronous write from the host
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_cmd;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Registered read, data is valid the cycle after rd_addr is presented.
  // Holding rd_addr keeps rd_cmd stable while the sequencer stalls
  always_ff @(posedge clk) begin
    rd_cmd <= mem[rd_addr];
  end

endmodule : cmd_store

// ==== hw/boot_sequencer.sv ====
// Producer side of the boot stub. Walks the command store from address 0 after start,
// turns write commands into queued register writes and stops on a halt command.

`timescale 1ns/1ns

module boot_sequencer #(
  parameter int unsigned CMD_AW = 5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,

  // Command store read port
  output logic [CMD_AW-1:0]     rd_addr,
  input  boot_pkg::cmd_t        rd_cmd,

  // Write queue push side
  input  logic                  full,
  output logic                  push,
  output boot_pkg::wr_req_t     push_req,

  output logic                  halted
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_issue,
    st_halt
  } state_t;

  state_t              state;
  state_t              state_d;
  logic [CMD_AW-1:0]   pc;
  logic [CMD_AW-1:0]   pc_d;
  logic                in_issue;
  logic                is_write;

  // ----------------------------------------
  // Issue decode
  // ----------------------------------------

  assign in_issue = (state == st_issue);
  assign is_write = (rd_cmd.op == boot_pkg::op_write);

  // Push only when the fetched write can be accepted this cycle
  assign push          = in_issue && is_write && !full;
  assign push_req.addr = rd_cmd.addr;
  assign push_req.data = rd_cmd.data;

  // The store always reads at pc, which keeps rd_cmd steady during a stall
  assign rd_addr = pc;

  assign halted = (state == st_halt);

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin
    state_d = state;
    pc_d    = pc;
    case (state)
      st_idle, st_halt: begin
        if (start) begin
          state_d = st_fetch;
          pc_d    = '0;
        end
      end
      st_fetch: begin
        state_d = st_issue;
      end
      st_issue: begin
        if (rd_cmd.op == boot_pkg::op_halt) begin
          state_d = st_halt;
        end else if (is_write) begin
          // Full queue keeps the command here until a slot frees up
          if (!full) begin
            state_d = st_fetch;
            pc_d    = pc + CMD_AW'(1);
          end
        end else begin
          // op_nop and unused encodings just advance
          state_d = st_fetch;
          pc_d    = pc + CMD_AW'(1);
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      pc    <= '0;
    end else begin
      state <= state_d;
      pc    <= pc_d;
    end
  end

endmodule : boot_sequencer

// ==== hw/write_queue.sv ====
// Synchronous FIFO of pending register writes between the sequencer and the MMIO block.
// Head is shown combinationally, a push and a pop may happen in the same cycle.

`timescale 1ns/1ns

module write_queue #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  push,
  input  boot_pkg::wr_req_t     push_req,

  input  logic                  pop,
  output boot_pkg::wr_req_t     head,

  output logic                  full,
  output logic                  empty
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  boot_pkg::wr_req_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                do_push;
  logic                do_pop;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Requests against a full or empty queue are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign head = mem[rd_ptr];

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_req;
    end
  end

  // ----------------------------------------
  // Pointers and level
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // Simultaneous push and pop leaves the level unchanged
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

endmodule : write_queue

// ==== hw/mmio_regs.sv ====
// MMIO register block of the boot stub. Drains the write queue and applies each write to
// the signature register, the power-off flag or the UART transmit port.

`timescale 1ns/1ns

module mmio_regs (
  input  logic                  clk,
  input  logic                  rst,

  // Write queue head
  input  boot_pkg::wr_req_t     head,
  input  logic                  empty,
  output logic                  pop,

  // UART transmit side
  input  logic                  uart_tx_ready,
  output logic                  uart_tx_valid,
  output logic [7:0]            uart_tx_byte,

  // System status
  output boot_pkg::data_t       signature,
  output logic                  poweroff
);

  logic hit_load;
  logic hit_xor;
  logic hit_off;
  logic hit_uart;
  logic uart_stall;

  // ----------------------------------------
  // Offset decode
  // ----------------------------------------

  assign hit_load = (head.addr == boot_pkg::reg_sig_load);
  assign hit_xor  = (head.addr == boot_pkg::reg_sig_xor);
  assign hit_off  = (head.addr == boot_pkg::reg_poweroff);
  assign hit_uart = (head.addr == boot_pkg::reg_uart_tx);

  // UART writes wait for the transmitter, everything else drains at once
  assign uart_stall = hit_uart && !uart_tx_ready;

  assign pop = !empty && !uart_stall;

  // ----------------------------------------
  // UART port
  // ----------------------------------------

  // One-cycle pulse in the cycle the UART write is popped
  assign uart_tx_valid = pop && hit_uart;
  assign uart_tx_byte  = head.data[7:0];

  // ----------------------------------------
  // Signature register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      signature <= '0;
    end else if (pop) begin
      if (hit_load) begin
        signature <= head.data;
      end else if (hit_xor) begin
        signature <= signature ^ head.data;
      end
    end
  end

  // ----------------------------------------
  // Power-off flag
  // ----------------------------------------

  // Sticky until reset, a zero write does nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      poweroff <= 1'b0;
    end else if (pop && hit_off && (head.data != '0)) begin
      poweroff <= 1'b1;
    end
  end

endmodule : mmio_regs

// ==== hw/boot_sys_top.sv ====
// Top level of the boot stub system. Connects the command store, the sequencer,
// the write queue and the MMIO register block, and sets their sizes.

`timescale 1ns/1ns

module boot_sys_top #(
  parameter int unsigned CMD_AW     = 5,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst,

  // Host load port, used only while idle or halted
  input  logic                  load_we,
  input  logic [CMD_AW-1:0]     load_addr,
  input  boot_pkg::cmd_t        load_cmd,

  input  logic                  start,
  input  logic                  uart_tx_ready,

  output boot_pkg::data_t       signature,
  output logic                  poweroff,
  output logic                  uart_tx_valid,
  output logic [7:0]            uart_tx_byte,
  output logic                  halted
);

  logic [CMD_AW-1:0]   rd_addr;
  boot_pkg::cmd_t      rd_cmd;
  logic                push;
  boot_pkg::wr_req_t   push_req;
  logic                full;
  logic                pop;
  boot_pkg::wr_req_t   head;
  logic                empty;

  // ----------------------------------------
  // Command store and sequencer
  // ----------------------------------------

  cmd_store #(
    .CMD_AW(CMD_AW)
  ) u_store (
    .clk(clk),
    .load_we(load_we),
    .load_addr(load_addr),
    .load_cmd(load_cmd),
    .rd_addr(rd_addr),
    .rd_cmd(rd_cmd)
  );

  boot_sequencer #(
    .CMD_AW(CMD_AW)
  ) u_seq (
    .clk(clk),
    .rst(rst),
    .start(start),
    .rd_addr(rd_addr),
    .rd_cmd(rd_cmd),
    .full(full),
    .push(push),
    .push_req(push_req),
    .halted(halted)
  );

  // ----------------------------------------
  // Write path
  // ----------------------------------------

  write_queue #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_queue (
    .clk(clk),
    .rst(rst),
    .push(push),
    .push_req(push_req),
    .pop(pop),
    .head(head),
    .full(full),
    .empty(empty)
  );

  mmio_regs u_mmio (
    .clk(clk),
    .rst(rst),
    .head(head),
    .empty(empty),
    .pop(pop),
    .uart_tx_ready(uart_tx_ready),
    .uart_tx_valid(uart_tx_valid),
    .uart_tx_byte(uart_tx_byte),
    .signature(signature),
    .poweroff(poweroff)
  );

endmodule : boot_sys_top

// ==== bench/boot_sys_tb.sv ====
// Self-checking testbench for the boot stub system. Runs seeded random boot programs
// through boot_sys_top and compares signature, UART bytes and status with a reference model.

`timescale 1ns/1ns

module boot_sys_tb;

  localparam int unsigned CMD_AW         = 5;
  localparam int unsigned FIFO_DEPTH     = 4;
  localparam int unsigned MAX_LEN        = 2 ** CMD_AW;
  localparam int unsigned NUM_PROGS      = 6;
  localparam int unsigned CYCLES_PER_CMD = 40;
  localparam int unsigned TIMEOUT_NS     = NUM_PROGS * MAX_LEN * CYCLES_PER_CMD * 8 + 4000;

  logic                clk = 1'b0;
  logic                rst;
  logic                load_we;
  logic [CMD_AW-1:0]   load_addr;
  boot_pkg::cmd_t      load_cmd;
  logic                start;
  logic                uart_tx_ready;
  boot_pkg::data_t     signature;
  logic                poweroff;
  logic                uart_tx_valid;
  logic [7:0]          uart_tx_byte;
  logic                halted;

  // Reference model state
  boot_pkg::data_t     exp_sig;
  logic [7:0]          exp_bytes [$];
  bit                  heavy_mode;

  boot_sys_top #(
    .CMD_AW(CMD_AW),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) DUT (
    .clk(clk),
    .rst(rst),
    .load_we(load_we),
    .load_addr(load_addr),
    .load_cmd(load_cmd),
    .start(start),
    .uart_tx_ready(uart_tx_ready),
    .signature(signature),
    .poweroff(poweroff),
    .uart_tx_valid(uart_tx_valid),
    .uart_tx_byte(uart_tx_byte),
    .halted(halted)
  );

  always #4 clk = ~clk;

  // ----------------------------------------
  // Checking helpers
  // ----------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                          $time, what, actual, expected));
    end
  endtask

  // ----------------------------------------
  // Program generation and model
  // ----------------------------------------

  // Heavy programs are mostly UART writes
  function automatic boot_pkg::addr_t pick_offset(input bit heavy);
    int unsigned     r;
    boot_pkg::addr_t unused [4] = '{8'h10, 8'h02, 8'h0d, 8'hfc};
    r = heavy ? $urandom_range(0, 9) : $urandom_range(0, 7);
    if (heavy) begin
      if (r < 7) return boot_pkg::reg_uart_tx;
      if (r == 7) return boot_pkg::reg_sig_xor;
      if (r == 8) return boot_pkg::reg_sig_load;
      return unused[$urandom_range(0, 3)];
    end
    case (r)
      0:       return boot_pkg::reg_sig_load;
      1, 2:    return boot_pkg::reg_sig_xor;
      3:       return boot_pkg::reg_uart_tx;
      4:       return boot_pkg::reg_poweroff;
      default: return unused[$urandom_range(0, 3)];
    endcase
  endfunction

  task automatic load_program(input int unsigned len, input bit heavy);
    boot_pkg::cmd_t cmd;
    exp_sig = '0;
    exp_bytes.delete();
    for (int unsigned i = 0; i < len; i++) begin
      cmd.addr = pick_offset(heavy);
      cmd.data = $urandom();
      cmd.op   = ($urandom_range(0, 4) == 0) ? boot_pkg::op_nop : boot_pkg::op_write;
      // Zero data keeps the power-off flag clear until the final write
      if (cmd.addr == boot_pkg::reg_poweroff) cmd.data = '0;
      if (i == len - 2) begin
        cmd.op   = boot_pkg::op_write;
        cmd.addr = boot_pkg::reg_poweroff;
        cmd.data = 32'd1;
      end else if (i == len - 1) begin
        cmd.op = boot_pkg::op_halt;
      end
      if (cmd.op == boot_pkg::op_write) begin
        case (cmd.addr)
          boot_pkg::reg_sig_load: exp_sig = cmd.data;
          boot_pkg::reg_sig_xor:  exp_sig = exp_sig ^ cmd.data;
          boot_pkg::reg_uart_tx:  exp_bytes.push_back(cmd.data[7:0]);
          default: ;
        endcase
      end
      @(negedge clk);
      load_we   = 1'b1;
      load_addr = CMD_AW'(i);
      load_cmd  = cmd;
    end
    @(negedge clk);
    load_we = 1'b0;
  endtask

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------

  task automatic apply_reset();
    @(negedge clk);
    rst     = 1'b1;
    start   = 1'b0;
    load_we = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic run_program(input int unsigned len);
    int unsigned cycles;
    logic        halt_seen;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    cycles    = 0;
    halt_seen = 1'b0;
    while (poweroff !== 1'b1) begin
      // The halt command can retire while queued writes are still draining
      if (halt_seen) begin
        check_value(halted, 1, "halted dropped before power-off");
      end
      halt_seen = halt_seen || (halted === 1'b1);
      if (cycles > len * CYCLES_PER_CMD) begin
        abort_run("program did not reach power-off in time");
      end
      @(negedge clk);
      cycles++;
    end
    check_value(signature, exp_sig, "signature at power-off");
    check_value(exp_bytes.size(), 0, "UART bytes still missing at power-off");
    cycles = 0;
    while (halted !== 1'b1) begin
      if (cycles > 8) abort_run("sequencer did not halt after the halt command");
      @(negedge clk);
      cycles++;
    end
    // Outputs must hold while halted
    repeat (16) begin
      @(negedge clk);
      check_value(halted, 1, "halted dropped");
      check_value(poweroff, 1, "poweroff dropped");
      check_value(signature, exp_sig, "signature after halt");
    end
  endtask

  // UART byte checker
  always @(posedge clk) begin : uart_monitor
    logic [7:0] want;
    if (rst === 1'b0 && uart_tx_valid === 1'b1) begin
      if (exp_bytes.size() == 0) begin
        abort_run("UART sent a byte that the program never wrote");
      end else begin
        want = exp_bytes.pop_front();
        check_value(uart_tx_byte, want, "UART byte");
      end
    end
  end

  // Random ready, or long low stretches in heavy mode
  initial begin : ready_driver
    int unsigned stretch;
    logic        level;
    stretch = 0;
    level   = 1'b1;
    forever begin
      @(negedge clk);
      if (!heavy_mode) begin
        uart_tx_ready = 1'($urandom_range(0, 1));
      end else begin
        if (stretch == 0) begin
          level   = !level;
          stretch = level ? $urandom_range(2, 8) : $urandom_range(10, 40);
        end
        stretch--;
        uart_tx_ready = level;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    abort_run($sformatf("timeout: run did not finish within %0d ns", TIMEOUT_NS));
  end

  initial begin : main_seq
    int unsigned seed_val;
    int unsigned len;
    bit          heavy;
    seed_val      = $urandom(32'hbc13_1395);
    rst           = 1'b1;
    load_we       = 1'b0;
    load_addr     = '0;
    load_cmd      = '0;
    start         = 1'b0;
    uart_tx_ready = 1'b0;
    heavy_mode    = 1'b0;
    for (int unsigned p = 0; p < NUM_PROGS; p++) begin
      heavy      = (p >= NUM_PROGS - 2);
      heavy_mode = heavy;
      len        = heavy ? MAX_LEN : $urandom_range(4, MAX_LEN);
      apply_reset();
      check_value(signature, 0, "signature after reset");
      check_value(poweroff, 0, "poweroff after reset");
      check_value(halted, 0, "halted after reset");
      check_value(uart_tx_valid, 0, "uart_tx_valid after reset");
      load_program(len, heavy);
      check_value(signature, 0, "signature before start");
      check_value(halted, 0, "halted before start");
      run_program(len);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule : boot_sys_tb

// ==== flist.f ====
hw/boot_pkg.sv
hw/cmd_store.sv
hw/boot_sequencer.sv
hw/write_queue.sv
hw/mmio_regs.sv
hw/boot_sys_top.sv
bench/boot_sys_tb.sv
